/* logic/dac_cfg_pkg.sv */
// DAC modulator constants
`default_nettype none

package dac_cfg_pkg;

    // Clock enable ring
    // One hot ring that fires the enable once per CEN_RING_LEN cycles
    localparam int CEN_RING_LEN = 4;

    // Single one in bit 2 puts the first enable two cycles after reset
    localparam logic [CEN_RING_LEN-1:0] CEN_RING_INIT = 4'b0100;

    // Modulator word
    // Unsigned input word with full scale at 2**PCM_W
    localparam int PCM_W = 20;

    // Integrators carry two extra bits over the input word
    // Enough for the second stage swing at half scale input
    localparam int ACC_W = PCM_W + 2;

endpackage

`default_nettype wire

/* logic/snd_fmt_pkg.sv */
// Sound sample word types
`default_nettype none

package snd_fmt_pkg;

    // Width of one core sample
    localparam int SAMPLE_W = 16;

    // Zero bits below the sample in the modulator word
    // The word value is the offset sample times 2**PAD_W
    localparam int PAD_W = 3;

    // One sample word read either way
    // sgn is two's complement and ofs is offset binary
    typedef union packed {
        logic signed [SAMPLE_W-1:0] sgn;
        logic        [SAMPLE_W-1:0] ofs;
    } snd_sample_u;

    // Modulator input word
    // From the top it holds the guard bit, the offset sample and PAD_W zeros
    // The zero guard bit keeps the word below half of full scale
    typedef logic [dac_cfg_pkg::PCM_W-1:0] pcm_word_t;

endpackage

`default_nettype wire

/* logic/snd_cen_gen.sv */
// DAC clock enable generator
`default_nettype none

module snd_cen_gen (
    input  logic clk_dac,
    input  logic rst,
    output logic cen_o
);

    // Rotating one hot ring
    logic [dac_cfg_pkg::CEN_RING_LEN-1:0] ring_q;

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            ring_q <= dac_cfg_pkg::CEN_RING_INIT;
        end else begin
            // Rotate left by one each cycle
            ring_q <= {ring_q[dac_cfg_pkg::CEN_RING_LEN-2:0],
                       ring_q[dac_cfg_pkg::CEN_RING_LEN-1]};
        end
    end

    // Bit 0 is the strobe that both channels share to stay in phase
    // Low during reset since the init value has bit 0 clear
    assign cen_o = ring_q[0];

endmodule

`default_nettype wire

/* logic/snd_pcm_format.sv */
// Sample formatter and channel routing
`default_nettype none

module snd_pcm_format (
    input  logic                     clk_dac,
    input  logic                     rst,
    input  logic                     cen_i,
    input  logic                     fmt_signed_i,
    input  logic                     stereo_i,
    input  snd_fmt_pkg::snd_sample_u snd_left_i,
    input  snd_fmt_pkg::snd_sample_u snd_right_i,
    output snd_fmt_pkg::pcm_word_t   pcm_left_o,
    output snd_fmt_pkg::pcm_word_t   pcm_right_o
);

    snd_fmt_pkg::snd_sample_u right_src;
    snd_fmt_pkg::pcm_word_t   left_word;
    snd_fmt_pkg::pcm_word_t   right_word;

    // Offset binary sample padded into the modulator word
    function automatic snd_fmt_pkg::pcm_word_t pad_sample(
        input snd_fmt_pkg::snd_sample_u smp,
        input logic                     is_signed
    );
        logic [snd_fmt_pkg::SAMPLE_W-1:0] ofs_val;

        if (is_signed) begin
            // Flip the sign bit of the two's complement view
            ofs_val = {~smp.sgn[snd_fmt_pkg::SAMPLE_W-1],
                       smp.sgn[snd_fmt_pkg::SAMPLE_W-2:0]};
        end else begin
            ofs_val = smp.ofs;
        end

        // Zero guard bit on top and zeros below make the word 8 times the offset value
        return {1'b0, ofs_val, {snd_fmt_pkg::PAD_W{1'b0}}};
    endfunction

    always_comb begin
        // Mono takes the left sample for both channels
        right_src  = stereo_i ? snd_right_i : snd_left_i;
        left_word  = pad_sample(snd_left_i, fmt_signed_i);
        right_word = pad_sample(right_src, fmt_signed_i);
    end

    // Inputs are levels taken only on the enable strobe
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            pcm_left_o  <= '0;
            pcm_right_o <= '0;
        end else if (cen_i) begin
            pcm_left_o  <= left_word;
            pcm_right_o <= right_word;
        end
    end

endmodule

`default_nettype wire

/* logic/snd_sd_dac.sv */
// Second-order sigma-delta DAC channel
`default_nettype none

module snd_sd_dac (
    input  logic                   clk_dac,
    input  logic                   rst,
    input  logic                   cen_i,
    input  snd_fmt_pkg::pcm_word_t pcm_i,
    output logic                   pwm_o
);

    // Integrator state, two's complement
    logic signed [dac_cfg_pkg::ACC_W-1:0] acc1_q;
    logic signed [dac_cfg_pkg::ACC_W-1:0] acc2_q;

    logic                                 quant;
    logic signed [dac_cfg_pkg::ACC_W-1:0] pcm_ext;
    logic signed [dac_cfg_pkg::ACC_W-1:0] fb;
    logic signed [dac_cfg_pkg::ACC_W:0]   err1;
    logic signed [dac_cfg_pkg::ACC_W:0]   err2;
    logic signed [dac_cfg_pkg::ACC_W-1:0] step1;
    logic signed [dac_cfg_pkg::ACC_W-1:0] step2;

    // Add with clamp at the integrator limits instead of wrapping
    function automatic logic signed [dac_cfg_pkg::ACC_W-1:0] sat_add(
        input logic signed [dac_cfg_pkg::ACC_W-1:0] a,
        input logic signed [dac_cfg_pkg::ACC_W-1:0] b
    );
        logic signed [dac_cfg_pkg::ACC_W:0] sum;

        sum = a + b;
        if (sum[dac_cfg_pkg::ACC_W] != sum[dac_cfg_pkg::ACC_W-1]) begin
            // On overflow pick the rail on the side of the true sign
            if (sum[dac_cfg_pkg::ACC_W]) begin
                return {1'b1, {(dac_cfg_pkg::ACC_W-1){1'b0}}};
            end
            return {1'b0, {(dac_cfg_pkg::ACC_W-1){1'b1}}};
        end
        return sum[dac_cfg_pkg::ACC_W-1:0];
    endfunction

    always_comb begin
        // Quantiser looks at the second integrator before it moves
        quant = ~acc2_q[dac_cfg_pkg::ACC_W-1] && (acc2_q != '0);

        pcm_ext = $signed({{(dac_cfg_pkg::ACC_W - dac_cfg_pkg::PCM_W){1'b0}}, pcm_i});

        // Full scale sits one bit above the input word
        fb                     = '0;
        fb[dac_cfg_pkg::PCM_W] = quant;

        err1 = pcm_ext - fb;
        err2 = acc1_q - fb;

        // Each stage integrates half of its error
        // Both halves fit back into ACC_W bits
        step1 = err1[dac_cfg_pkg::ACC_W:1];
        step2 = err2[dac_cfg_pkg::ACC_W:1];
    end

    // Everything moves on the enable only, so pwm edges stay on the enable grid
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            acc1_q <= '0;
            acc2_q <= '0;
            pwm_o  <= 1'b0;
        end else if (cen_i) begin
            acc1_q <= sat_add(acc1_q, step1);
            acc2_q <= sat_add(acc2_q, step2);
            pwm_o  <= quant;
        end
    end

endmodule

`default_nettype wire

/* logic/snd_out_top.sv */
// Sound output top level
`default_nettype none

module snd_out_top (
    input  logic                            clk_dac,
    input  logic                            rst,
    input  logic                            fmt_signed_i,
    input  logic                            stereo_i,
    input  logic [snd_fmt_pkg::SAMPLE_W-1:0] snd_left_i,
    input  logic [snd_fmt_pkg::SAMPLE_W-1:0] snd_right_i,
    output logic                            snd_pwm_left_o,
    output logic                            snd_pwm_right_o
);

    logic                     cen;
    snd_fmt_pkg::snd_sample_u left_smp;
    snd_fmt_pkg::snd_sample_u right_smp;
    snd_fmt_pkg::pcm_word_t   pcm_left;
    snd_fmt_pkg::pcm_word_t   pcm_right;
    logic                     pwm_left;
    logic                     pwm_right;

    // Plain sample pins seen through the union type
    assign left_smp  = snd_left_i;
    assign right_smp = snd_right_i;

    snd_cen_gen u_cen (
        .clk_dac ( clk_dac ),
        .rst     ( rst     ),
        .cen_o   ( cen     )
    );

    snd_pcm_format u_fmt (
        .clk_dac      ( clk_dac      ),
        .rst          ( rst          ),
        .cen_i        ( cen          ),
        .fmt_signed_i ( fmt_signed_i ),
        .stereo_i     ( stereo_i     ),
        .snd_left_i   ( left_smp     ),
        .snd_right_i  ( right_smp    ),
        .pcm_left_o   ( pcm_left     ),
        .pcm_right_o  ( pcm_right    )
    );

    snd_sd_dac u_dac_left (
        .clk_dac ( clk_dac  ),
        .rst     ( rst      ),
        .cen_i   ( cen      ),
        .pcm_i   ( pcm_left ),
        .pwm_o   ( pwm_left )
    );

    snd_sd_dac u_dac_right (
        .clk_dac ( clk_dac   ),
        .rst     ( rst       ),
        .cen_i   ( cen       ),
        .pcm_i   ( pcm_right ),
        .pwm_o   ( pwm_right )
    );

    assign snd_pwm_left_o = pwm_left;

    // In mono the right pin repeats the left pin cycle for cycle,
    // whatever state the right modulator was left in
    assign snd_pwm_right_o = stereo_i ? pwm_right : pwm_left;

endmodule

`default_nettype wire

/* tests/snd_checker.sv */
// PWM output checker
`default_nettype none

module snd_checker #(
    parameter int NAME_LEN   = 16,
    parameter int TOL_CYCLES = 16
) (
    input  logic                  clk_dac,
    input  logic                  rst,
    input  logic                  pwm_left_i,
    input  logic                  pwm_right_i,
    input  logic                  stereo_i,
    input  logic                  start_i,
    input  logic [8*NAME_LEN-1:0] name_i,
    input  int                    window_i,
    input  int                    exp_left_i,
    input  int                    exp_right_i,
    output logic                  done_o,
    output int                    pass_cnt_o,
    output int                    fail_cnt_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // Pins may only move on the one-in-four enable
    localparam int ENABLE_PERIOD = 4;

    logic                  active;
    logic                  in_reset;
    int                    reset_cycles;
    int                    reset_high;
    logic [8*NAME_LEN-1:0] cur_name;
    int                    cur_window;
    int                    cur_exp_left;
    int                    cur_exp_right;
    int                    idx;
    int                    cnt_left;
    int                    cnt_right;
    int                    last_edge;
    int                    first_gap;
    int                    off_grid;
    int                    mono_miss;
    logic                  prev_left;
    logic                  prev_right;

    initial begin
        active       = 1'b0;
        in_reset     = 1'b0;
        reset_cycles = 0;
        reset_high   = 0;
        done_o       = 1'b0;
        pass_cnt_o   = 0;
        fail_cnt_o   = 0;
    end

    // Packed name to text with the zero bytes dropped
    function automatic string name_text(input logic [8*NAME_LEN-1:0] raw);
        string      txt;
        logic [7:0] ch;
        int         i;

        txt = "";
        for (i = NAME_LEN - 1; i >= 0; i--) begin
            ch = raw[8*i +: 8];
            if (ch != 8'h00) begin
                txt = $sformatf("%s%c", txt, ch);
            end
        end
        return txt;
    endfunction

    function automatic logic within_tol(input int actual, input int expected);
        return (actual >= expected - TOL_CYCLES) && (actual <= expected + TOL_CYCLES);
    endfunction

    task automatic begin_window();
        cur_name      = name_i;
        cur_window    = window_i;
        cur_exp_left  = exp_left_i;
        cur_exp_right = exp_right_i;
        idx           = 0;
        cnt_left      = 0;
        cnt_right     = 0;
        last_edge     = -1;
        first_gap     = 0;
        off_grid      = 0;
        mono_miss     = 0;
        done_o        = 1'b0;
        active        = 1'b1;
    endtask

    task automatic take_sample();
        if (pwm_left_i) begin
            cnt_left = cnt_left + 1;
        end
        if (pwm_right_i) begin
            cnt_right = cnt_right + 1;
        end
        // In mono the right pin is the left pin
        if (!stereo_i && (pwm_left_i != pwm_right_i)) begin
            mono_miss = mono_miss + 1;
        end
        // Gap to the previous edge on either pin
        if (idx > 0 && (pwm_left_i != prev_left || pwm_right_i != prev_right)) begin
            if (last_edge >= 0 && ((idx - last_edge) % ENABLE_PERIOD) != 0) begin
                if (off_grid == 0) begin
                    first_gap = idx - last_edge;
                end
                off_grid = off_grid + 1;
            end
            last_edge = idx;
        end
        prev_left  = pwm_left_i;
        prev_right = pwm_right_i;
        idx        = idx + 1;
    endtask

    task automatic report_test();
        string nm;
        logic  failed;

        nm     = name_text(cur_name);
        failed = 1'b0;
        if (!within_tol(cnt_left, cur_exp_left)) begin
            $display("** Error %s: left pin high cycles expected %0d, actual %0d",
                     nm, cur_exp_left, cnt_left);
            failed = 1'b1;
        end
        if (!within_tol(cnt_right, cur_exp_right)) begin
            $display("** Error %s: right pin high cycles expected %0d, actual %0d",
                     nm, cur_exp_right, cnt_right);
            failed = 1'b1;
        end
        if (off_grid != 0) begin
            $display("Test %s: %0d pin edges broke the enable timing, first gap %0d cycles",
                     nm, off_grid, first_gap);
            failed = 1'b1;
        end
        if (mono_miss != 0) begin
            $display("Test %s: right pin did not repeat the left pin on %0d cycles in mono",
                     nm, mono_miss);
            failed = 1'b1;
        end
        if (failed) begin
            fail_cnt_o = fail_cnt_o + 1;
            $display("FAIL %s", nm);
        end else begin
            pass_cnt_o = pass_cnt_o + 1;
            $display("PASS %s: left %0d, right %0d high cycles of %0d", nm, cnt_left,
                     cnt_right, cur_window);
        end
    endtask

    task automatic report_reset();
        if (reset_high != 0) begin
            fail_cnt_o = fail_cnt_o + 1;
            $display("Test reset: a pwm pin was high on %0d of %0d reset cycles",
                     reset_high, reset_cycles);
            $display("FAIL reset");
        end else begin
            pass_cnt_o = pass_cnt_o + 1;
            $display("PASS reset: both pins low for %0d reset cycles", reset_cycles);
        end
    endtask

    always @(posedge clk_dac) begin
        if (rst) begin
            in_reset     = 1'b1;
            reset_cycles = reset_cycles + 1;
            if (pwm_left_i || pwm_right_i) begin
                reset_high = reset_high + 1;
            end
        end else begin
            if (in_reset) begin
                report_reset();
                in_reset = 1'b0;
            end
            if (active) begin
                take_sample();
                if (idx >= cur_window) begin
                    report_test();
                    active = 1'b0;
                    done_o = 1'b1;
                end
            end else if (start_i) begin
                begin_window();
            end
        end
    end

endmodule

`default_nettype wire

/* tests/tb_snd_out.sv */
// Sound output testbench
`default_nettype none

module tb_snd_out;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 10;
    // 512 enable periods
    localparam int SETTLE_CYCLES = 2048;
    // Four enable periods
    localparam int TOL_CYCLES    = 16;
    localparam int NAME_LEN      = 16;
    localparam int MAX_TESTS     = 64;

    logic                  clk_dac;
    logic                  rst;
    logic                  fmt_signed;
    logic                  stereo;
    logic [15:0]           snd_left;
    logic [15:0]           snd_right;
    logic                  snd_pwm_left;
    logic                  snd_pwm_right;

    logic                  start;
    logic [8*NAME_LEN-1:0] test_name;
    int                    window;
    int                    exp_left;
    int                    exp_right;
    logic                  chk_done;
    int                    pass_cnt;
    int                    fail_cnt;

    // Test table read from the data file
    logic [8*NAME_LEN-1:0] name_tab   [MAX_TESTS];
    logic                  signed_tab [MAX_TESTS];
    logic                  stereo_tab [MAX_TESTS];
    logic [15:0]           left_tab   [MAX_TESTS];
    logic [15:0]           right_tab  [MAX_TESTS];
    int                    window_tab [MAX_TESTS];
    int                    n_tests;

    int                    cycle_cnt   = 0;
    int                    cycle_limit = 0;

    snd_out_top i_snd_out_top (
        .clk_dac         ( clk_dac       ),
        .rst             ( rst           ),
        .fmt_signed_i    ( fmt_signed    ),
        .stereo_i        ( stereo        ),
        .snd_left_i      ( snd_left      ),
        .snd_right_i     ( snd_right     ),
        .snd_pwm_left_o  ( snd_pwm_left  ),
        .snd_pwm_right_o ( snd_pwm_right )
    );

    snd_checker #(
        .NAME_LEN   ( NAME_LEN   ),
        .TOL_CYCLES ( TOL_CYCLES )
    ) u_checker (
        .clk_dac     ( clk_dac       ),
        .rst         ( rst           ),
        .pwm_left_i  ( snd_pwm_left  ),
        .pwm_right_i ( snd_pwm_right ),
        .stereo_i    ( stereo        ),
        .start_i     ( start         ),
        .name_i      ( test_name     ),
        .window_i    ( window        ),
        .exp_left_i  ( exp_left      ),
        .exp_right_i ( exp_right     ),
        .done_o      ( chk_done      ),
        .pass_cnt_o  ( pass_cnt      ),
        .fail_cnt_o  ( fail_cnt      )
    );

    initial begin
        clk_dac = 1'b0;
        forever #(CLK_PERIOD / 2) clk_dac = ~clk_dac;
    end

    // Offset binary is two's complement shifted up by half scale
    function automatic logic [15:0] offset_of(input logic [15:0] smp, input logic is_signed);
        if (is_signed) begin
            return smp + 16'h8000;
        end
        return smp;
    endfunction

    // Density 8u / 2**20 gives u / 131072 of the window
    function automatic int expected_high(input int win, input logic [15:0] u);
        longint prod;

        prod = longint'(win) * longint'(u);
        return int'(prod / 131072);
    endfunction

    task automatic load_tests(output logic ok);
        int                    fd;
        int                    got;
        string                 line;
        logic [8*NAME_LEN-1:0] nm;
        int                    sg;
        int                    st;
        logic [15:0]           smp_l;
        logic [15:0]           smp_r;
        int                    win;

        n_tests = 0;
        ok      = 1'b0;
        fd      = $fopen("tests/snd_input.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                line = "";
                got  = $fgets(line, fd);
                // Skip blank lines and column notes
                if (got > 0 && line.len() > 0 && line.getc(0) != 8'h23) begin
                    nm  = '0;
                    got = $sscanf(line, "%s %d %d %h %h %d", nm, sg, st, smp_l, smp_r, win);
                    if (got == 6) begin
                        name_tab[n_tests]   = nm;
                        signed_tab[n_tests] = (sg != 0);
                        stereo_tab[n_tests] = (st != 0);
                        left_tab[n_tests]   = smp_l;
                        right_tab[n_tests]  = smp_r;
                        window_tab[n_tests] = win;
                        n_tests             = n_tests + 1;
                    end
                end
            end
            $fclose(fd);
            ok = (n_tests > 0);
        end
    endtask

    task automatic run_test(input int idx);
        logic [15:0] u_left;
        logic [15:0] u_right;

        @(negedge clk_dac);
        fmt_signed = signed_tab[idx];
        stereo     = stereo_tab[idx];
        snd_left   = left_tab[idx];
        snd_right  = right_tab[idx];
        repeat (SETTLE_CYCLES) @(negedge clk_dac);

        u_left  = offset_of(left_tab[idx], signed_tab[idx]);
        u_right = stereo_tab[idx] ? offset_of(right_tab[idx], signed_tab[idx]) : u_left;

        test_name = name_tab[idx];
        window    = window_tab[idx];
        exp_left  = expected_high(window_tab[idx], u_left);
        exp_right = expected_high(window_tab[idx], u_right);
        start     = 1'b1;
        @(negedge clk_dac);
        start = 1'b0;
        while (!chk_done) @(negedge clk_dac);
    endtask

    // Run length guard
    always @(posedge clk_dac) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("Timeout: the run went past %0d clock cycles", cycle_limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        logic file_ok;
        int   total;
        int   i;

        rst        = 1'b1;
        fmt_signed = 1'b0;
        stereo     = 1'b1;
        snd_left   = '0;
        snd_right  = '0;
        start      = 1'b0;
        test_name  = '0;
        window     = 0;
        exp_left   = 0;
        exp_right  = 0;

        load_tests(file_ok);
        if (!file_ok) begin
            $display("No tests could be read from tests/snd_input.txt");
            $display("CHECKS FAILED");
            $finish;
        end else begin
            total = RESET_CYCLES;
            for (i = 0; i < n_tests; i++) begin
                total = total + SETTLE_CYCLES + window_tab[i];
            end
            cycle_limit = total * 5 / 4;

            repeat (RESET_CYCLES) @(negedge clk_dac);
            rst = 1'b0;

            for (i = 0; i < n_tests; i++) begin
                run_test(i);
            end
            @(negedge clk_dac);

            $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
            if (fail_cnt == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* filelist.f */
logic/dac_cfg_pkg.sv
logic/snd_fmt_pkg.sv
logic/snd_cen_gen.sv
logic/snd_pcm_format.sv
logic/snd_sd_dac.sv
logic/snd_out_top.sv
tests/snd_checker.sv
tests/tb_snd_out.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the sound output testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --timescale 1ns/1ps \
    --top-module tb_snd_out \
    -f filelist.f \
    -o sim_snd_out

sim_out=$(./obj_dir/sim_snd_out)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "ALL CHECKS PASSED"; then
    echo "Simulation result: pass"
    exit 0
else
    echo "Simulation result: fail"
    exit 1
fi

/* tests/snd_input.txt */
# name  signed  stereo  left(hex)  right(hex)  window(clock cycles)
# signed and stereo are 0 or 1, samples are the raw 16-bit core words
sgn_min         1 1 8000 8000 4096
sgn_zero        1 1 0000 0000 4096
sgn_max         1 1 7fff 7fff 4096
sgn_neg_half    1 1 c000 c000 4096
sgn_pos_half    1 1 4000 4000 4096
sgn_small       1 1 0010 fff0 4096
uns_mid         0 1 8000 8000 4096
uns_zero        0 1 0000 0000 4096
uns_max         0 1 ffff ffff 4096
uns_low         0 1 0100 0100 8192
uns_quarter     0 1 4000 4000 2048

# stereo, each pin follows its own sample
st_sgn_split    1 1 7fff 8000 4096
st_sgn_mixed    1 1 c000 2000 4096
st_uns_split    0 1 2000 e000 4096
st_uns_edge     0 1 ffff 0000 4096
st_uns_mixed    0 1 a5a5 5a5a 2048

# mono, right pin repeats the left pin
mono_sgn_a      1 0 7fff 8000 4096
mono_sgn_b      1 0 c000 7fff 4096
mono_uns_a      0 0 2000 e000 4096
mono_uns_b      0 0 0000 ffff 4096
mono_uns_c      0 0 9000 1000 2048

# back to stereo after mono
st_return       1 1 1234 edcb 4096
